/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= loop_unroll_tb
RTL_TOP   ?= loop_unroll_top
FILELIST  ?= loop_unroll.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/loop_unroll_macros.svh */
`ifndef LOOP_UNROLL_MACROS_SVH
`define LOOP_UNROLL_MACROS_SVH

// fetch side
`define LU_ADDR_W 16
`define LU_LANES 4

// conditional branch major opcode
`define LU_BR_OPCODE 4'hB

// loop address table entries
`define LU_LAT_DEPTH 4

// instructions the loop buffer holds before fetch must stall
`define LU_BUF_BUDGET 64

`endif

/* loop_unroll.f */
+incdir+include
verilog/fetch_types_pkg.sv
verilog/loop_types_pkg.sv
verilog/backward_branch_detect.sv
verilog/unroll_limit_rom.sv
verilog/loop_address_table.sv
verilog/unroll_dispatcher.sv
verilog/loop_unroll_top.sv
verification/tb_clock_gen.sv
verification/loop_unroll_tb.sv

/* verification/loop_unroll_tb.sv */
`timescale 1ns/1ps
`include "loop_unroll_macros.svh"

module loop_unroll_tb
	import fetch_types_pkg::*;
	import loop_types_pkg::*;
();

	logic        clk;
	logic        rst;
	logic        fetch_valid;
	addr_t       fetch_pc;
	logic [63:0] fetch_insts;
	logic        mis_pred;
	logic        loop_start;
	lane_mask_t  inst_valid;
	logic        stall_fetch;
	logic        finish_unroll;
	logic [1:0]  lbd_state;

	integer  seed;
	logic    exp_hit; // stimulus expects a table hit this cycle
	addr_t   exp_end;
	unroll_t exp_unroll;
	int      fin_seen;

	// dispatch model
	logic       m_active;
	lane_mask_t m_mask;
	logic       m_stall;
	logic       m_fin;
	int         m_budget;
	addr_t      m_end;
	unroll_t    m_rem;

	tb_clock_gen i_tb_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	loop_unroll_top i_loop_unroll_top (
		.clk           (clk),
		.rst           (rst),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.fetch_insts   (fetch_insts),
		.mis_pred      (mis_pred),
		.loop_start    (loop_start),
		.inst_valid    (inst_valid),
		.stall_fetch   (stall_fetch),
		.finish_unroll (finish_unroll),
		.lbd_state     (lbd_state)
	);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	function automatic unroll_t ref_max_unroll(input int len);
		if (len <= 0 || len > 64)
			return '0;
		return unroll_t'(64 / len);
	endfunction

	// lane of the loop end inside the group at pc, or -1
	function automatic int ref_end_lane(input addr_t end_pc, input addr_t pc);
		addr_t d;
		d = end_pc - pc;
		if (d < 16 && d[1:0] == 2'b00)
			return int'(d[3:2]);
		return -1;
	endfunction

	function automatic lane_mask_t ref_mask(input int lane);
		logic [3:0] m;
		m = 4'b1111;
		if (lane >= 0)
			m = m << (3 - lane);
		return m;
	endfunction

	function automatic inst_t filler_inst();
		inst_t w;
		w = inst_t'($random(seed));
		if (w[15:12] == `LU_BR_OPCODE)
			w[15:12] = 4'hA; // never a branch
		return w;
	endfunction

	// group at pc of a loop at start with len instructions, branch on the last one
	function automatic logic [63:0] build_group(input addr_t pc, input addr_t start,
		input int len);
		logic [63:0] g;
		addr_t       a;
		for (int i = 0; i < 4; i++) begin
			a = pc + addr_t'(4*i);
			if (len > 1 && a == start + addr_t'(4*(len-1)))
				g[(3-i)*16 +: 16] = {4'hB, 12'(-(len-1))};
			else
				g[(3-i)*16 +: 16] = filler_inst();
		end
		return g;
	endfunction

	task automatic drive_group(input addr_t pc, input logic [63:0] insts, input logic hit,
		input int hit_len);
		int waited;
		waited = 0;
		@(negedge clk);
		while (stall_fetch) begin
			fetch_valid = 1'b0;
			exp_hit = 1'b0;
			waited++;
			if (waited > 8)
				stop_with_error("stall_fetch stayed high too long");
			@(negedge clk);
		end
		fetch_valid = 1'b1;
		fetch_pc = pc;
		fetch_insts = insts;
		exp_hit = hit;
		if (hit) begin
			exp_end = pc + addr_t'(4*(hit_len-1));
			exp_unroll = ref_max_unroll(hit_len);
		end
		#1;
		assert (loop_start == hit) else
			stop_with_error($sformatf("MISMATCH loop_start: got %h expected %h at pc %h",
				loop_start, hit, pc));
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			fetch_valid = 1'b0;
			exp_hit = 1'b0;
			mis_pred = 1'b0;
		end
	endtask

	task automatic abort_cycle();
		@(negedge clk);
		fetch_valid = 1'b0;
		exp_hit = 1'b0;
		mis_pred = 1'b1;
		@(negedge clk);
		mis_pred = 1'b0;
	endtask

	task automatic wait_state(input lbd_state_t st, input int limit);
		int waited;
		waited = 0;
		while (lbd_state != st) begin
			waited++;
			if (waited > limit)
				stop_with_error($sformatf("lbd_state never reached %s", st.name()));
			@(negedge clk);
		end
	endtask

	task automatic run_pass(input addr_t start, input int len);
		for (int g = 0; g < (len + 3) / 4; g++)
			drive_group(start + addr_t'(16*g), build_group(start + addr_t'(16*g), start, len),
				1'b0, 0);
	endtask

	task automatic train_loop(input addr_t start, input int len);
		run_pass(start, len);
		idle(1);
		wait_state(LBD_TRAIN, 8);
		run_pass(start, len); // measuring pass
		idle(1);
		wait_state(LBD_IDLE, 8);
	endtask

	always begin : compare_outputs
		int lane;
		int base;
		@(posedge clk);
		if (rst) begin
			m_active = 1'b0;
			m_mask = 4'hF;
			m_stall = 1'b0;
			m_fin = 1'b0;
			m_budget = 0;
		end else begin
			m_stall = 1'b0;
			m_fin = 1'b0;
			if (mis_pred) begin
				m_active = 1'b0;
				m_mask = 4'hF;
				m_budget = 0;
			end else if (exp_hit) begin
				m_active = 1'b1;
				m_budget = 0;
				m_end = exp_end;
				m_rem = exp_unroll;
			end else if (m_active) begin
				base = (m_budget >= 64) ? 0 : m_budget;
				if (fetch_valid) begin
					lane = ref_end_lane(m_end, fetch_pc);
					m_mask = ref_mask(lane);
					base += $countones(m_mask);
					if (lane >= 0) begin
						m_rem = m_rem - 1'b1;
						if (m_rem == '0) begin
							m_fin = 1'b1;
							m_active = 1'b0;
						end
					end
				end
				m_budget = base;
				m_stall = (m_budget == 64);
			end else begin
				m_mask = 4'hF;
			end
		end
		@(negedge clk);
		assert (inst_valid == m_mask) else
			stop_with_error($sformatf("MISMATCH inst_valid: got %h expected %h",
				inst_valid, m_mask));
		assert (stall_fetch == m_stall) else
			stop_with_error($sformatf("MISMATCH stall_fetch: got %h expected %h",
				stall_fetch, m_stall));
		assert (finish_unroll == m_fin) else
			stop_with_error($sformatf("MISMATCH finish_unroll: got %h expected %h",
				finish_unroll, m_fin));
		if (m_active)
			assert (lbd_state == LBD_DISPATCH) else
				stop_with_error($sformatf("MISMATCH lbd_state: got %h expected %h",
					lbd_state, LBD_DISPATCH));
		if (finish_unroll)
			fin_seen++;
	end

	initial begin : stimulus
		int waited;
		seed = 32'hc9a8cf87;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fetch_insts = '0;
		mis_pred = 1'b0;
		exp_hit = 1'b0;
		exp_end = '0;
		exp_unroll = '0;
		fin_seen = 0;
		waited = 0;
		@(negedge clk);
		while (rst) begin
			waited++;
			if (waited > 20)
				stop_with_error("reset never released");
			@(negedge clk);
		end

		// reset state, empty table
		assert (inst_valid == 4'hF && !stall_fetch && !finish_unroll
			&& lbd_state == LBD_IDLE) else
			stop_with_error($sformatf("MISMATCH reset outputs: inst_valid %h stall %h fin %h state %h",
				inst_valid, stall_fetch, finish_unroll, lbd_state));
		drive_group(16'h0100, build_group(16'h0100, 16'h0100, 0), 1'b0, 0);
		idle(2);

		// 6 instruction loop, branch in lane 1 of group 2
		train_loop(16'h1000, 6);
		drive_group(16'h1000, build_group(16'h1000, 16'h1000, 6), 1'b1, 6);
		for (int p = 0; p < 10; p++) begin
			drive_group(16'h1000, build_group(16'h1000, 16'h1000, 6), 1'b0, 0);
			drive_group(16'h1010, build_group(16'h1010, 16'h1000, 6), 1'b0, 0);
		end
		idle(3);
		assert (fin_seen == 1) else
			stop_with_error($sformatf("MISMATCH finish count: got %h expected %h", fin_seen, 1));
		assert (lbd_state == LBD_IDLE) else
			stop_with_error($sformatf("MISMATCH lbd_state: got %h expected %h",
				lbd_state, LBD_IDLE));

		// too long to store, the branch retrains so abort it
		train_loop(16'h2000, 70);
		wait_state(LBD_TRAIN, 8);
		abort_cycle();
		wait_state(LBD_IDLE, 8);
		drive_group(16'h2000, build_group(16'h2000, 16'h2000, 0), 1'b0, 0);
		idle(2);

		// four more loops push the first one out
		train_loop(16'h3000, 8);
		train_loop(16'h4000, 7);
		train_loop(16'h5000, 9);
		train_loop(16'h5800, 12);
		drive_group(16'h1000, build_group(16'h1000, 16'h1000, 0), 1'b0, 0);
		idle(1);
		drive_group(16'h3000, build_group(16'h3000, 16'h3000, 0), 1'b1, 8);
		abort_cycle();
		drive_group(16'h4000, build_group(16'h4000, 16'h4000, 0), 1'b1, 7);
		abort_cycle();
		drive_group(16'h5000, build_group(16'h5000, 16'h5000, 0), 1'b1, 9);
		abort_cycle();
		drive_group(16'h5800, build_group(16'h5800, 16'h5800, 0), 1'b1, 12);
		abort_cycle();
		idle(2);

		// 4 instruction loop, full groups until the budget stalls
		train_loop(16'h6000, 4);
		drive_group(16'h6000, build_group(16'h6000, 16'h6000, 4), 1'b1, 4);
		repeat (16)
			drive_group(16'h6010, build_group(16'h6010, 16'h6000, 0), 1'b0, 0);
		@(negedge clk);
		fetch_valid = 1'b0;
		assert (stall_fetch == 1'b1) else
			stop_with_error($sformatf("MISMATCH stall_fetch: got %h expected %h",
				stall_fetch, 1'b1));
		mis_pred = 1'b1;
		@(negedge clk);
		mis_pred = 1'b0;
		idle(3);
		assert (fin_seen == 1) else
			stop_with_error($sformatf("MISMATCH finish count: got %h expected %h", fin_seen, 1));
		assert (lbd_state == LBD_IDLE) else
			stop_with_error($sformatf("MISMATCH lbd_state: got %h expected %h",
				lbd_state, LBD_IDLE));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* verilog/backward_branch_detect.sv */
`timescale 1ns/1ps
`include "loop_unroll_macros.svh"

module backward_branch_detect
	import fetch_types_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              fetch_valid,
	input  addr_t                             fetch_pc,
	input  logic [`LU_LANES*$bits(inst_t)-1:0] fetch_insts,
	output logic                              bb_hit,
	output addr_t                             bb_pc,
	output addr_t                             bb_target
);

	inst_t                lane_inst [`LU_LANES];
	addr_t                lane_pc   [`LU_LANES];
	addr_t                lane_tgt  [`LU_LANES];
	logic [`LU_LANES-1:0] lane_bb;
	logic                 sel_hit;
	lane_idx_t            sel_lane;

	// per lane decode, lane 0 sits in the top bits
	always_comb begin
		for (int i = 0; i < `LU_LANES; i++) begin
			lane_inst[i] = fetch_insts[(`LU_LANES-1-i)*$bits(inst_t) +: $bits(inst_t)];
			lane_pc[i] = fetch_pc + addr_t'(4*i);
			lane_bb[i] = fetch_valid && lane_inst[i][15:12] == `LU_BR_OPCODE
				&& lane_inst[i][11]; // negative offset only
			lane_tgt[i] = lane_pc[i] + {{2{lane_inst[i][11]}}, lane_inst[i][11:0], 2'b00};
		end
	end

	// lowest lane wins
	always_comb begin
		sel_hit = 1'b0;
		sel_lane = '0;
		for (int i = `LU_LANES-1; i >= 0; i--) begin
			if (lane_bb[i]) begin
				sel_hit = 1'b1;
				sel_lane = lane_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			bb_hit <= 1'b0;
		else
			bb_hit <= sel_hit;
	end

	always_ff @(posedge clk) begin
		bb_pc <= lane_pc[sel_lane];
		bb_target <= lane_tgt[sel_lane];
	end

endmodule

/* verilog/fetch_types_pkg.sv */
`include "loop_unroll_macros.svh"

package fetch_types_pkg;

	// byte address of an instruction, lanes are 4 apart
	typedef logic [`LU_ADDR_W-1:0] addr_t;

	// [15:12] opcode, [11:0] signed word offset
	typedef logic [15:0] inst_t;

	typedef logic [`LU_LANES-1:0] lane_mask_t; // lane 0 in msb

	typedef logic [$clog2(`LU_LANES)-1:0] lane_idx_t;

endpackage

/* verilog/loop_address_table.sv */
`timescale 1ns/1ps
`include "loop_unroll_macros.svh"

module loop_address_table
	import fetch_types_pkg::*;
	import loop_types_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       fetch_valid,
	input  addr_t      fetch_pc,
	input  logic       bb_hit,
	input  addr_t      bb_pc,
	input  addr_t      bb_target,
	input  logic       mis_pred,
	input  logic       disp_active,
	output logic       hit_valid,
	output addr_t      hit_fallthrough,
	output unroll_t    hit_unroll,
	output logic [1:0] lbd_state
);

	logic      ent_valid  [`LU_LAT_DEPTH];
	addr_t     ent_start  [`LU_LAT_DEPTH];
	addr_t     ent_fall   [`LU_LAT_DEPTH];
	unroll_t   ent_unroll [`LU_LAT_DEPTH];
	lat_idx_t  rr_ptr;

	lbd_state_t state;
	addr_t      tr_start;
	addr_t      tr_fall;
	body_len_t  tr_len;
	logic       tr_counting;

	logic [`LU_LAT_DEPTH-1:0] pc_hits;
	logic                     tgt_known;
	lat_idx_t                 pc_idx;

	addr_t     end_diff;
	logic      end_in_group;
	lane_idx_t end_lane;
	logic      tr_group;
	logic      wr_en;
	body_len_t len_base;
	body_len_t len_next;
	unroll_t   max_unroll;

	function automatic logic [`LU_LAT_DEPTH-1:0] start_match(input addr_t addr);
		logic [`LU_LAT_DEPTH-1:0] m;
		for (int i = 0; i < `LU_LAT_DEPTH; i++)
			m[i] = ent_valid[i] && ent_start[i] == addr;
		return m;
	endfunction

	always_comb begin
		pc_hits = start_match(fetch_pc);
		tgt_known = |start_match(bb_target); // loop already stored
		pc_idx = '0;
		for (int i = `LU_LAT_DEPTH-1; i >= 0; i--) begin
			if (pc_hits[i])
				pc_idx = lat_idx_t'(i);
		end
	end

	assign hit_valid = fetch_valid && !disp_active && |pc_hits;
	assign hit_fallthrough = ent_fall[pc_idx];
	assign hit_unroll = ent_unroll[pc_idx];
	assign lbd_state = disp_active ? LBD_DISPATCH : state;

	// where the branch lane falls in this group
	assign end_diff = tr_fall - addr_t'(4) - fetch_pc;
	assign end_in_group = end_diff[`LU_ADDR_W-1:4] == '0 && end_diff[1:0] == 2'b00;
	assign end_lane = end_diff[3:2];

	assign tr_group = state == LBD_TRAIN && fetch_valid && !mis_pred && !hit_valid
		&& (tr_counting || fetch_pc == tr_start);

	always_comb begin
		len_base = tr_counting ? tr_len : '0;
		if (len_base > body_len_t'(`LU_BUF_BUDGET))
			len_next = len_base; // saturate, loop is too long anyway
		else if (end_in_group)
			len_next = len_base + body_len_t'(end_lane) + 1'b1;
		else
			len_next = len_base + body_len_t'(`LU_LANES);
	end

	unroll_limit_rom i_unroll_limit_rom (
		.body_len   (len_next),
		.max_unroll (max_unroll)
	);

	assign wr_en = tr_group && end_in_group && max_unroll != '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LBD_IDLE;
			tr_counting <= 1'b0;
			rr_ptr <= '0;
			for (int i = 0; i < `LU_LAT_DEPTH; i++)
				ent_valid[i] <= 1'b0;
		end else begin
			case (state)
				LBD_IDLE: begin
					tr_counting <= 1'b0;
					if (bb_hit && !hit_valid && !disp_active && !tgt_known && !mis_pred)
						state <= LBD_TRAIN;
				end
				LBD_TRAIN: begin
					if (mis_pred || hit_valid) begin
						state <= LBD_IDLE; // abort, nothing written
					end else if (tr_group) begin
						tr_counting <= 1'b1;
						if (end_in_group)
							state <= LBD_IDLE;
					end
					if (wr_en) begin
						ent_valid[rr_ptr] <= 1'b1;
						rr_ptr <= rr_ptr + 1'b1;
					end
				end
				default: state <= LBD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == LBD_IDLE && bb_hit) begin
			tr_start <= bb_target;
			tr_fall <= bb_pc + addr_t'(4);
		end
		if (tr_group)
			tr_len <= len_next;
		if (wr_en) begin
			ent_start[rr_ptr] <= tr_start;
			ent_fall[rr_ptr] <= tr_fall;
			ent_unroll[rr_ptr] <= max_unroll;
		end
	end

endmodule

/* verilog/loop_types_pkg.sv */
`include "loop_unroll_macros.svh"

package loop_types_pkg;

	// wide enough to hold the full buffer budget
	typedef logic [$clog2(`LU_BUF_BUDGET):0] body_len_t;
	typedef logic [$clog2(`LU_BUF_BUDGET):0] unroll_t;

	typedef logic [$clog2(`LU_LAT_DEPTH)-1:0] lat_idx_t;

	typedef enum logic [1:0] {
		LBD_IDLE     = 2'd0,
		LBD_TRAIN    = 2'd1,
		LBD_DISPATCH = 2'd2
	} lbd_state_t;

endpackage

/* verilog/loop_unroll_top.sv */
`timescale 1ns/1ps
`include "loop_unroll_macros.svh"

module loop_unroll_top
	import fetch_types_pkg::*;
	import loop_types_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              fetch_valid,
	input  addr_t                             fetch_pc,
	input  logic [`LU_LANES*$bits(inst_t)-1:0] fetch_insts,
	input  logic                              mis_pred,
	output logic                              loop_start,
	output lane_mask_t                        inst_valid,
	output logic                              stall_fetch,
	output logic                              finish_unroll,
	output logic [1:0]                        lbd_state
);

	logic    bb_hit;
	addr_t   bb_pc;
	addr_t   bb_target;
	logic    hit_valid;
	addr_t   hit_fallthrough;
	unroll_t hit_unroll;
	logic    disp_active;

	assign loop_start = hit_valid;

	backward_branch_detect i_backward_branch_detect (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_insts (fetch_insts),
		.bb_hit      (bb_hit),
		.bb_pc       (bb_pc),
		.bb_target   (bb_target)
	);

	loop_address_table i_loop_address_table (
		.clk             (clk),
		.rst             (rst),
		.fetch_valid     (fetch_valid),
		.fetch_pc        (fetch_pc),
		.bb_hit          (bb_hit),
		.bb_pc           (bb_pc),
		.bb_target       (bb_target),
		.mis_pred        (mis_pred),
		.disp_active     (disp_active),
		.hit_valid       (hit_valid),
		.hit_fallthrough (hit_fallthrough),
		.hit_unroll      (hit_unroll),
		.lbd_state       (lbd_state)
	);

	unroll_dispatcher i_unroll_dispatcher (
		.clk             (clk),
		.rst             (rst),
		.fetch_valid     (fetch_valid),
		.fetch_pc        (fetch_pc),
		.hit_valid       (hit_valid),
		.hit_fallthrough (hit_fallthrough),
		.hit_unroll      (hit_unroll),
		.mis_pred        (mis_pred),
		.disp_active     (disp_active),
		.inst_valid      (inst_valid),
		.stall_fetch     (stall_fetch),
		.finish_unroll   (finish_unroll)
	);

endmodule

/* verilog/unroll_dispatcher.sv */
`timescale 1ns/1ps
`include "loop_unroll_macros.svh"

module unroll_dispatcher
	import fetch_types_pkg::*;
	import loop_types_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       fetch_valid,
	input  addr_t      fetch_pc,
	input  logic       hit_valid,
	input  addr_t      hit_fallthrough,
	input  unroll_t    hit_unroll,
	input  logic       mis_pred,
	output logic       disp_active,
	output lane_mask_t inst_valid,
	output logic       stall_fetch,
	output logic       finish_unroll
);

	addr_t      end_pc; // pc of the backward branch
	unroll_t    remaining;
	unroll_t    rem_next;
	body_len_t  budget;
	body_len_t  budget_base;
	body_len_t  budget_next;
	body_len_t  mask_cnt;
	addr_t      end_diff;
	logic       end_in_group;
	lane_idx_t  end_lane;
	logic       group_en;
	lane_mask_t mask;

	assign group_en = disp_active && fetch_valid;

	assign end_diff = end_pc - fetch_pc;
	assign end_in_group = end_diff[`LU_ADDR_W-1:4] == '0 && end_diff[1:0] == 2'b00;
	assign end_lane = end_diff[3:2];

	// ones up to and including the end lane
	assign mask = end_in_group ?
		~(lane_mask_t'({(`LU_LANES-1){1'b1}}) >> end_lane) : '1;
	assign mask_cnt = end_in_group ? body_len_t'(end_lane) + 1'b1 : body_len_t'(`LU_LANES);

	assign rem_next = remaining - 1'b1;

	// counter clears once the buffer budget has been reached
	assign budget_base = (budget >= body_len_t'(`LU_BUF_BUDGET)) ? '0 : budget;
	assign budget_next = group_en ? budget_base + mask_cnt : budget_base;

	always_ff @(posedge clk) begin
		if (rst) begin
			disp_active <= 1'b0;
			inst_valid <= '1;
			stall_fetch <= 1'b0;
			finish_unroll <= 1'b0;
			budget <= '0;
		end else begin
			finish_unroll <= 1'b0;
			stall_fetch <= 1'b0;
			if (mis_pred) begin
				disp_active <= 1'b0; // no finish strobe
				inst_valid <= '1;
				budget <= '0;
			end else if (hit_valid) begin
				disp_active <= 1'b1;
				budget <= '0;
			end else if (disp_active) begin
				budget <= budget_next;
				stall_fetch <= budget_next == body_len_t'(`LU_BUF_BUDGET);
				if (fetch_valid) begin
					inst_valid <= mask;
					if (end_in_group && rem_next == '0) begin
						finish_unroll <= 1'b1;
						disp_active <= 1'b0;
					end
				end
			end else begin
				inst_valid <= '1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit_valid) begin
			end_pc <= hit_fallthrough - addr_t'(4);
			remaining <= hit_unroll;
		end else if (group_en && end_in_group) begin
			remaining <= rem_next; // one pass done
		end
	end

endmodule

/* verilog/unroll_limit_rom.sv */
`timescale 1ns/1ps

module unroll_limit_rom
	import loop_types_pkg::*;
(
	input  body_len_t body_len,
	output unroll_t   max_unroll
);

	// floor(64 / len), zero keeps the loop out of the table
	always_comb begin
		case (body_len) inside
			7'd1:           max_unroll = 7'd64;
			7'd2:           max_unroll = 7'd32;
			7'd3:           max_unroll = 7'd21;
			7'd4:           max_unroll = 7'd16;
			7'd5:           max_unroll = 7'd12;
			7'd6:           max_unroll = 7'd10;
			7'd7:           max_unroll = 7'd9;
			7'd8:           max_unroll = 7'd8;
			7'd9:           max_unroll = 7'd7;
			7'd10:          max_unroll = 7'd6;
			[7'd11:7'd12]:  max_unroll = 7'd5;
			[7'd13:7'd16]:  max_unroll = 7'd4;
			[7'd17:7'd21]:  max_unroll = 7'd3;
			[7'd22:7'd32]:  max_unroll = 7'd2;
			[7'd33:7'd64]:  max_unroll = 7'd1;
			default:        max_unroll = 7'd0; // empty or too long
		endcase
	end

endmodule
